//--- rd_engine_pkg.sv
//==========================================================================
// Read engine package
// Widths, AXI encodings and vector types shared by the read engine blocks
//==========================================================================

package rd_engine_pkg;

    // Channel count and channel number width
    localparam int NUM_CHANNELS = 4;
    localparam int CH_ID_WIDTH  = 2;

    // AXI bus widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    // Channel number sits in the low ID bits
    localparam int ID_WIDTH   = 4;

    // Scheduler beat count and SRAM free-space count
    localparam int BEATS_WIDTH = 16;
    localparam int SPACE_WIDTH = 8;

    //==========================================================================
    // AXI encodings
    //==========================================================================
    // 8 bytes per beat
    localparam logic [2:0] AXSIZE_BEAT = 3'd3;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] RESP_OKAY   = 2'b00;

    //==========================================================================
    // Vector types
    //==========================================================================
    typedef logic [NUM_CHANNELS-1:0] ch_mask_t;
    typedef logic [CH_ID_WIDTH-1:0]  ch_id_t;
    typedef logic [ID_WIDTH-1:0]     axi_id_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    // ARLEN or a beat count of one burst
    typedef logic [7:0]              len_t;
    typedef logic [BEATS_WIDTH-1:0]  beats_t;
    typedef logic [SPACE_WIDTH-1:0]  space_t;
    typedef logic [1:0]              resp_t;

endpackage

//--- rd_request_mask.sv
//==========================================================================
// Read request mask
// Sizes the next burst of each channel and keeps a channel in the
// arbiter request only when it is valid, fits in SRAM and is idle
//==========================================================================

`timescale 1ns/1ps

module rd_request_mask (
    input  rd_engine_pkg::len_t                                    cfg_xfer_len,
    input  rd_engine_pkg::ch_mask_t                                sched_rd_valid,
    input  rd_engine_pkg::beats_t [rd_engine_pkg::NUM_CHANNELS-1:0] sched_rd_beats,
    input  rd_engine_pkg::space_t [rd_engine_pkg::NUM_CHANNELS-1:0] alloc_space_free,
    input  rd_engine_pkg::ch_mask_t                                outstanding,
    output rd_engine_pkg::len_t   [rd_engine_pkg::NUM_CHANNELS-1:0] burst_len,
    output rd_engine_pkg::ch_mask_t                                arb_request
);

    import rd_engine_pkg::*;

    // Channel has room for its whole next burst
    ch_mask_t space_ok;

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            // Tail burst takes what is left, else a full configured burst
            if (sched_rd_beats[i] <= beats_t'(cfg_xfer_len) + beats_t'(1)) begin
                burst_len[i] = len_t'(sched_rd_beats[i] - beats_t'(1));
            end else begin
                burst_len[i] = cfg_xfer_len;
            end

            // One extra bit so a 256 beat burst compares correctly
            space_ok[i] = ({1'b0, alloc_space_free[i]} >= (9'(burst_len[i]) + 9'd1));

            // Only one burst per channel may be in flight
            arb_request[i] = sched_rd_valid[i] && space_ok[i] && !outstanding[i];
        end
    end

endmodule

//--- rd_rr_arbiter.sv
//==========================================================================
// Round-robin arbiter
// Grants the first requester at or after a rotating pointer; the pointer
// moves past the winner only once the grant is acknowledged
//==========================================================================

`timescale 1ns/1ps

module rd_rr_arbiter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  rd_engine_pkg::ch_mask_t request,
    input  logic                    grant_ack,
    output logic                    grant_valid,
    output rd_engine_pkg::ch_id_t   grant_id
);

    import rd_engine_pkg::*;

    // Highest priority channel for the next grant
    ch_id_t ptr;

    //==========================================================================
    // Grant selection
    //==========================================================================
    // Scan from the farthest channel back to the pointer so that the
    // nearest requester is written last and wins
    always_comb begin
        ch_id_t idx;
        grant_valid = 1'b0;
        grant_id    = '0;
        for (int k = NUM_CHANNELS - 1; k >= 0; k--) begin
            // Two bit sum wraps around the channel ring
            idx = ptr + ch_id_t'(k);
            if (request[idx]) begin
                grant_valid = 1'b1;
                grant_id    = idx;
            end
        end
    end

    //==========================================================================
    // Priority pointer
    //==========================================================================
    // Held while the AR command waits for arready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (grant_ack) begin
            ptr <= grant_id + 1'b1;
        end
    end

    // Acknowledge comes back from the AR handshake in the issue block
    a_ack_with_grant : assert property (
        @(posedge clk) disable iff (!arst_n)
        grant_ack |-> grant_valid
    );

endmodule

//--- rd_channel_tracker.sv
//==========================================================================
// Channel tracker
// Per-channel burst-in-flight flags and sticky read-error flags
//==========================================================================

`timescale 1ns/1ps

module rd_channel_tracker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ar_fire,
    input  rd_engine_pkg::ch_id_t   ar_ch,
    input  logic                    r_fire,
    input  rd_engine_pkg::ch_id_t   r_ch,
    input  logic                    r_last,
    input  rd_engine_pkg::resp_t    r_resp,
    output rd_engine_pkg::ch_mask_t outstanding,
    output rd_engine_pkg::ch_mask_t rd_error
);

    import rd_engine_pkg::*;

    //==========================================================================
    // Outstanding flags
    //==========================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= '0;
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                // Set on the channel's AR handshake
                if (ar_fire && (ar_ch == ch_id_t'(i))) begin
                    outstanding[i] <= 1'b1;
                end
                // Last beat written after the set, so clear wins
                if (r_fire && r_last && (r_ch == ch_id_t'(i))) begin
                    outstanding[i] <= 1'b0;
                end
            end
        end
    end

    //==========================================================================
    // Sticky error flags
    //==========================================================================
    // Any non-OKAY beat marks its channel until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_error <= '0;
        end else if (r_fire && (r_resp != RESP_OKAY)) begin
            rd_error[r_ch] <= 1'b1;
        end
    end

    // RID of a last beat must name a channel with a burst in flight
    a_last_outstanding : assert property (
        @(posedge clk) disable iff (!arst_n)
        (r_fire && r_last) |-> outstanding[r_ch]
    );

endmodule

//--- rd_ar_issue.sv
//==========================================================================
// AR issue
// Drives the AR command from the granted channel and, one cycle after
// the handshake, pulses the SRAM pre-allocation and the issued strobe
//==========================================================================

`timescale 1ns/1ps

module rd_ar_issue (
    input  logic                                                   clk,
    input  logic                                                   arst_n,
    input  logic                                                   grant_valid,
    input  rd_engine_pkg::ch_id_t                                  grant_id,
    input  rd_engine_pkg::addr_t  [rd_engine_pkg::NUM_CHANNELS-1:0] sched_rd_addr,
    input  rd_engine_pkg::len_t   [rd_engine_pkg::NUM_CHANNELS-1:0] burst_len,
    input  logic                                                   m_axi_arready,
    output logic                                                   m_axi_arvalid,
    output rd_engine_pkg::axi_id_t                                 m_axi_arid,
    output rd_engine_pkg::addr_t                                   m_axi_araddr,
    output rd_engine_pkg::len_t                                    m_axi_arlen,
    output logic [2:0]                                             m_axi_arsize,
    output logic [1:0]                                             m_axi_arburst,
    output logic                                                   ar_fire,
    output logic                                                   alloc_req,
    output rd_engine_pkg::len_t                                    alloc_size,
    output rd_engine_pkg::axi_id_t                                 alloc_id,
    output rd_engine_pkg::ch_mask_t                                issued,
    output rd_engine_pkg::len_t   [rd_engine_pkg::NUM_CHANNELS-1:0] issued_beats
);

    import rd_engine_pkg::*;

    //==========================================================================
    // AR command
    //==========================================================================
    // Combinational so arvalid drops the cycle a channel loses its space
    assign m_axi_arvalid = grant_valid;
    // Channel number in the low ID bits, upper bits zero
    assign m_axi_arid    = axi_id_t'(grant_id);
    assign m_axi_araddr  = sched_rd_addr[grant_id];
    assign m_axi_arlen   = burst_len[grant_id];
    assign m_axi_arsize  = AXSIZE_BEAT;
    assign m_axi_arburst = BURST_INCR;

    // Handshake also acknowledges the arbiter grant
    assign ar_fire = m_axi_arvalid && m_axi_arready;

    //==========================================================================
    // Registered strobes
    //==========================================================================
    // Single cycle pulses after each accepted AR
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alloc_req <= 1'b0;
            issued    <= '0;
        end else begin
            alloc_req <= ar_fire;
            issued    <= ar_fire ? (ch_mask_t'(1) << grant_id) : '0;
        end
    end

    // Beat count is ARLEN plus one
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            alloc_size             <= m_axi_arlen + len_t'(1);
            alloc_id               <= m_axi_arid;
            issued_beats[grant_id] <= m_axi_arlen + len_t'(1);
        end
    end

endmodule

//--- axi_read_engine.sv
//==========================================================================
// AXI4 read engine
// Four-channel read engine: space-aware request masking, round-robin
// AR arbitration, SRAM pre-allocation and an unbuffered R to SRAM path
//==========================================================================

`timescale 1ns/1ps

module axi_read_engine (
    input  logic                                                   clk,
    input  logic                                                   arst_n,
    // Largest ARLEN of one burst
    input  rd_engine_pkg::len_t                                    cfg_xfer_len,

    // Scheduler requests, one entry per channel
    input  rd_engine_pkg::ch_mask_t                                sched_rd_valid,
    input  rd_engine_pkg::addr_t  [rd_engine_pkg::NUM_CHANNELS-1:0] sched_rd_addr,
    input  rd_engine_pkg::beats_t [rd_engine_pkg::NUM_CHANNELS-1:0] sched_rd_beats,
    input  rd_engine_pkg::space_t [rd_engine_pkg::NUM_CHANNELS-1:0] alloc_space_free,
    output rd_engine_pkg::ch_mask_t                                sched_rd_issued,
    output rd_engine_pkg::len_t   [rd_engine_pkg::NUM_CHANNELS-1:0] sched_rd_issued_beats,
    output rd_engine_pkg::ch_mask_t                                sched_rd_error,

    // SRAM pre-allocation
    output logic                                                   alloc_req,
    output rd_engine_pkg::len_t                                    alloc_size,
    output rd_engine_pkg::axi_id_t                                 alloc_id,

    // SRAM write port
    output logic                                                   sram_valid,
    input  logic                                                   sram_ready,
    output rd_engine_pkg::axi_id_t                                 sram_id,
    output rd_engine_pkg::data_t                                   sram_data,

    // AXI AR
    output logic                                                   m_axi_arvalid,
    input  logic                                                   m_axi_arready,
    output rd_engine_pkg::axi_id_t                                 m_axi_arid,
    output rd_engine_pkg::addr_t                                   m_axi_araddr,
    output rd_engine_pkg::len_t                                    m_axi_arlen,
    output logic [2:0]                                             m_axi_arsize,
    output logic [1:0]                                             m_axi_arburst,

    // AXI R
    input  logic                                                   m_axi_rvalid,
    output logic                                                   m_axi_rready,
    input  rd_engine_pkg::axi_id_t                                 m_axi_rid,
    input  rd_engine_pkg::data_t                                   m_axi_rdata,
    input  rd_engine_pkg::resp_t                                   m_axi_rresp,
    input  logic                                                   m_axi_rlast
);

    import rd_engine_pkg::*;

    ch_mask_t                   outstanding;
    ch_mask_t                   arb_request;
    len_t [NUM_CHANNELS-1:0]    burst_len;
    logic                       grant_valid;
    ch_id_t                     grant_id;
    logic                       ar_fire;
    logic                       r_fire;

    //==========================================================================
    // Request masking and arbitration
    //==========================================================================
    rd_request_mask u_rd_request_mask (
        .cfg_xfer_len     (cfg_xfer_len),
        .sched_rd_valid   (sched_rd_valid),
        .sched_rd_beats   (sched_rd_beats),
        .alloc_space_free (alloc_space_free),
        .outstanding      (outstanding),
        .burst_len        (burst_len),
        .arb_request      (arb_request)
    );

    rd_rr_arbiter u_rd_rr_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .request     (arb_request),
        .grant_ack   (ar_fire),
        .grant_valid (grant_valid),
        .grant_id    (grant_id)
    );

    //==========================================================================
    // AR issue and channel state
    //==========================================================================
    rd_ar_issue u_rd_ar_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .grant_valid   (grant_valid),
        .grant_id      (grant_id),
        .sched_rd_addr (sched_rd_addr),
        .burst_len     (burst_len),
        .m_axi_arready (m_axi_arready),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arid    (m_axi_arid),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arlen   (m_axi_arlen),
        .m_axi_arsize  (m_axi_arsize),
        .m_axi_arburst (m_axi_arburst),
        .ar_fire       (ar_fire),
        .alloc_req     (alloc_req),
        .alloc_size    (alloc_size),
        .alloc_id      (alloc_id),
        .issued        (sched_rd_issued),
        .issued_beats  (sched_rd_issued_beats)
    );

    // Channel of a beat comes from the low RID bits
    rd_channel_tracker u_rd_channel_tracker (
        .clk         (clk),
        .arst_n      (arst_n),
        .ar_fire     (ar_fire),
        .ar_ch       (grant_id),
        .r_fire      (r_fire),
        .r_ch        (m_axi_rid[CH_ID_WIDTH-1:0]),
        .r_last      (m_axi_rlast),
        .r_resp      (m_axi_rresp),
        .outstanding (outstanding),
        .rd_error    (sched_rd_error)
    );

    //==========================================================================
    // R to SRAM pass-through
    //==========================================================================
    // No buffering, SRAM back-pressure goes straight to rready
    assign sram_valid   = m_axi_rvalid;
    assign sram_id      = m_axi_rid;
    assign sram_data    = m_axi_rdata;
    assign m_axi_rready = sram_ready;
    assign r_fire       = m_axi_rvalid && sram_ready;

endmodule

//--- tb_axi_read_engine_model.svh
//==========================================================================
// Read engine reference model
// Burst sizing, request masking, round-robin choice and the expected
// outstanding and sticky error flags, tracked once per clock edge
//==========================================================================

`ifndef TB_AXI_READ_ENGINE_MODEL_SVH
`define TB_AXI_READ_ENGINE_MODEL_SVH

// Model copies of the pointer and the per-channel flags
ch_id_t   model_ptr;
ch_mask_t model_outst;
ch_mask_t model_err;

// Full configured burst unless fewer beats are left
function automatic len_t model_burst_len(input len_t cfg, input beats_t beats);
    logic [16:0] limit;
    beats_t      tail;
    limit = {9'd0, cfg} + 17'd1;
    tail  = beats - 16'd1;
    if ({1'b0, beats} <= limit) begin
        return tail[7:0];
    end
    return cfg;
endfunction

// Valid, room for the whole burst, and nothing in flight
function automatic ch_mask_t model_request(
    input len_t                       cfg,
    input ch_mask_t                   valid,
    input beats_t [NUM_CHANNELS-1:0]  beats,
    input space_t [NUM_CHANNELS-1:0]  space,
    input ch_mask_t                   outst
);
    ch_mask_t   req;
    logic [8:0] need;
    for (int i = 0; i < NUM_CHANNELS; i++) begin
        need   = {1'b0, model_burst_len(cfg, beats[i])} + 9'd1;
        req[i] = valid[i] && ({1'b0, space[i]} >= need) && !outst[i];
    end
    return req;
endfunction

// First requester at or after the pointer, wrapping upward
function automatic ch_id_t model_pick(input ch_mask_t req, input ch_id_t ptr);
    ch_id_t ch;
    for (int k = 0; k < NUM_CHANNELS; k++) begin
        ch = ptr + k[1:0];
        if (req[ch]) begin
            return ch;
        end
    end
    return ptr;
endfunction

task automatic model_reset();
    model_ptr   = '0;
    model_outst = '0;
    model_err   = '0;
endtask

// State after the coming edge; a last beat clears after the set
task automatic model_step(
    input logic   ar_fire,
    input ch_id_t ar_ch,
    input logic   r_fire,
    input ch_id_t r_ch,
    input logic   r_last,
    input resp_t  r_resp
);
    if (ar_fire) begin
        model_outst[ar_ch] = 1'b1;
        model_ptr          = ar_ch + 2'd1;
    end
    if (r_fire && r_last) begin
        model_outst[r_ch] = 1'b0;
    end
    if (r_fire && (r_resp != 2'b00)) begin
        model_err[r_ch] = 1'b1;
    end
endtask

`endif

//--- tb_axi_read_engine.sv
//==========================================================================
// Read engine testbench
// Random scheduler traffic and an AXI slave responder, checked each
// cycle against a reference model of masking, arbitration and flags
//==========================================================================

`timescale 1ns/1ps

module tb_axi_read_engine;

    import rd_engine_pkg::*;

    localparam int NUM_TESTS    = 3;
    localparam int TEST_CYCLES  = 400;
    localparam int RESET_CYCLES = 5;
    localparam int CLK_PERIOD   = 10;
    // Twice the length of all tests
    localparam int WATCHDOG_NS  = 2 * NUM_TESTS * (TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD;

    logic                      clk;
    logic                      arst_n;
    len_t                      cfg_xfer_len;
    ch_mask_t                  sched_rd_valid;
    addr_t  [NUM_CHANNELS-1:0] sched_rd_addr;
    beats_t [NUM_CHANNELS-1:0] sched_rd_beats;
    space_t [NUM_CHANNELS-1:0] alloc_space_free;
    ch_mask_t                  sched_rd_issued;
    len_t   [NUM_CHANNELS-1:0] sched_rd_issued_beats;
    ch_mask_t                  sched_rd_error;
    logic                      alloc_req;
    len_t                      alloc_size;
    axi_id_t                   alloc_id;
    logic                      sram_valid;
    logic                      sram_ready;
    axi_id_t                   sram_id;
    data_t                     sram_data;
    logic                      m_axi_arvalid;
    logic                      m_axi_arready;
    axi_id_t                   m_axi_arid;
    addr_t                     m_axi_araddr;
    len_t                      m_axi_arlen;
    logic [2:0]                m_axi_arsize;
    logic [1:0]                m_axi_arburst;
    logic                      m_axi_rvalid;
    logic                      m_axi_rready;
    axi_id_t                   m_axi_rid;
    data_t                     m_axi_rdata;
    resp_t                     m_axi_rresp;
    logic                      m_axi_rlast;

    // Traffic profile of the running test
    int space_max;
    int sram_ready_pct;
    int arready_pct;
    int err_pct;
    bit draining;

    // Responder queue of accepted bursts, served in order
    ch_id_t burst_ch_q[$];
    int     burst_beats_q[$];
    int     beat_idx;
    bit     r_fire_seen;
    int     bursts;
    int     beats_issued;
    int     beats_written;

    // Strobes expected one cycle after a handshake
    bit     exp_alloc;
    ch_id_t exp_ch;
    len_t   exp_beats;

    int     errors;
    int     checks;
    int     test_errors;
    string  test_name [NUM_TESTS] = '{"random traffic", "back-pressure", "error responses"};

    `include "tb_axi_read_engine_model.svh"

    axi_read_engine u_axi_read_engine (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    //==========================================================================
    // Stimulus
    //==========================================================================
    // Scheduler inputs change now and then so requests stay up a while
    task automatic drive_inputs();
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if ($urandom_range(3) == 0) begin
                sched_rd_valid[i]   = ($urandom_range(3) != 0);
                sched_rd_addr[i]    = $urandom;
                sched_rd_beats[i]   = beats_t'($urandom_range(40, 1));
                alloc_space_free[i] = space_t'($urandom_range(space_max));
            end
            if (draining) begin
                sched_rd_valid[i] = 1'b0;
            end
        end
        m_axi_arready = ($urandom_range(99) < arready_pct);
        sram_ready    = ($urandom_range(99) < sram_ready_pct);
    endtask

    // AXI slave R side; a beat holds until the SRAM side takes it
    task automatic drive_r_channel();
        if (r_fire_seen) begin
            beat_idx++;
            if (m_axi_rlast) begin
                burst_ch_q.delete(0);
                burst_beats_q.delete(0);
                beat_idx = 0;
            end
            m_axi_rvalid = 1'b0;
        end
        if (!m_axi_rvalid && (burst_ch_q.size() > 0) && ($urandom_range(3) != 0)) begin
            m_axi_rvalid = 1'b1;
            m_axi_rid    = axi_id_t'(burst_ch_q[0]);
            m_axi_rdata  = {$urandom, $urandom};
            m_axi_rresp  = ($urandom_range(99) < err_pct) ? 2'b10 : 2'b00;
            m_axi_rlast  = (beat_idx == burst_beats_q[0] - 1);
        end
    endtask

    task automatic apply_reset(input int test);
        arst_n         = 1'b0;
        draining       = 1'b0;
        sched_rd_valid = '0;
        m_axi_arready  = 1'b0;
        sram_ready     = 1'b0;
        m_axi_rvalid   = 1'b0;
        m_axi_rlast    = 1'b0;
        burst_ch_q.delete();
        burst_beats_q.delete();
        beat_idx       = 0;
        bursts         = 0;
        beats_issued   = 0;
        beats_written  = 0;
        case (test)
            0: begin
                cfg_xfer_len   = len_t'($urandom_range(15));
                space_max      = 40;
                sram_ready_pct = 80;
                arready_pct    = 70;
                err_pct        = 3;
            end
            // Low space and a slow SRAM side
            1: begin
                cfg_xfer_len   = len_t'($urandom_range(7));
                space_max      = 10;
                sram_ready_pct = 25;
                arready_pct    = 50;
                err_pct        = 3;
            end
            default: begin
                cfg_xfer_len   = len_t'($urandom_range(3));
                space_max      = 255;
                sram_ready_pct = 90;
                arready_pct    = 90;
                err_pct        = 30;
            end
        endcase
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    //==========================================================================
    // Checker sampled at the falling edge where all outputs are settled
    //==========================================================================
    always @(negedge clk) begin
        ch_mask_t req;
        ch_id_t   ch;
        len_t     len;
        bit       ar_fire;
        bit       r_fire;
        ch        = '0;
        len       = '0;
        if (!arst_n) begin
            model_reset();
            exp_alloc   = 1'b0;
            r_fire_seen = 1'b0;
            compare_value("alloc_req", alloc_req, 0);
            compare_value("sched_rd_issued", sched_rd_issued, 0);
            compare_value("sched_rd_error", sched_rd_error, 0);
            compare_value("m_axi_arvalid", m_axi_arvalid, 0);
        end else begin
            req = model_request(cfg_xfer_len, sched_rd_valid, sched_rd_beats,
                                alloc_space_free, model_outst);
            compare_value("m_axi_arvalid", m_axi_arvalid, |req);
            if (|req) begin
                ch  = model_pick(req, model_ptr);
                len = model_burst_len(cfg_xfer_len, sched_rd_beats[ch]);
                compare_value("m_axi_arid", m_axi_arid, ch);
                compare_value("m_axi_araddr", m_axi_araddr, sched_rd_addr[ch]);
                compare_value("m_axi_arlen", m_axi_arlen, len);
                compare_value("m_axi_arsize", m_axi_arsize, 3'd3);
                compare_value("m_axi_arburst", m_axi_arburst, 2'b01);
            end

            // Pulses only in the cycle after a handshake
            compare_value("alloc_req", alloc_req, exp_alloc);
            compare_value("sched_rd_issued", sched_rd_issued,
                          exp_alloc ? (4'b0001 << exp_ch) : 4'b0000);
            if (exp_alloc) begin
                compare_value("alloc_size", alloc_size, exp_beats);
                compare_value("alloc_id", alloc_id, exp_ch);
                compare_value("sched_rd_issued_beats", sched_rd_issued_beats[exp_ch], exp_beats);
            end

            // R to SRAM pass-through
            compare_value("sram_valid", sram_valid, m_axi_rvalid);
            compare_value("sram_id", sram_id, m_axi_rid);
            compare_value("sram_data", sram_data, m_axi_rdata);
            compare_value("m_axi_rready", m_axi_rready, sram_ready);
            compare_value("sched_rd_error", sched_rd_error, model_err);

            // Handshakes of the coming edge
            ar_fire     = (|req) && m_axi_arready;
            r_fire      = m_axi_rvalid && sram_ready;
            r_fire_seen = r_fire;
            exp_alloc   = ar_fire;
            if (ar_fire) begin
                exp_ch    = ch;
                exp_beats = len + 8'd1;
                burst_ch_q.push_back(ch);
                burst_beats_q.push_back(int'(len) + 1);
                beats_issued += int'(len) + 1;
                bursts++;
            end
            // Beats the SRAM port takes
            if (sram_valid && sram_ready) begin
                beats_written++;
            end
            model_step(ar_fire, ch, r_fire, m_axi_rid[1:0], m_axi_rlast, m_axi_rresp);
        end
    end

    //==========================================================================
    // Test sequence
    //==========================================================================
    initial begin
        void'($urandom(61));
        arst_n           = 1'b0;
        cfg_xfer_len     = '0;
        sched_rd_valid   = '0;
        sched_rd_addr    = '0;
        sched_rd_beats   = '0;
        alloc_space_free = '0;
        sram_ready       = 1'b0;
        m_axi_arready    = 1'b0;
        m_axi_rvalid     = 1'b0;
        m_axi_rid        = '0;
        m_axi_rdata      = '0;
        m_axi_rresp      = '0;
        m_axi_rlast      = 1'b0;
        errors           = 0;
        checks           = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = errors;
            @(posedge clk);
            #1;
            apply_reset(t);
            repeat (TEST_CYCLES) begin
                @(posedge clk);
                #1;
                drive_inputs();
                drive_r_channel();
            end
            // Stop new requests and let every burst complete
            draining = 1'b1;
            do begin
                @(posedge clk);
                #1;
                drive_inputs();
                drive_r_channel();
            end while ((burst_ch_q.size() != 0) || (model_outst != '0));
            compare_value("beats written to SRAM", beats_written, beats_issued);
            $display("test %0d %s: %0d bursts, %0d beats, %0d errors", t, test_name[t],
                     bursts, beats_written, errors - test_errors);
        end
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- axi_read_engine.f
+incdir+.
rd_engine_pkg.sv
rd_request_mask.sv
rd_rr_arbiter.sv
rd_channel_tracker.sv
rd_ar_issue.sv
axi_read_engine.sv
tb_axi_read_engine.sv
